// ==== Makefile ====
# Verilator flow for the alu testbench
TOP = tb_alu
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f alu.f --top-module $(TOP)

# the run passes only when the log holds the pass line
sim:
	verilator --binary --timing --assert -j 0 -f alu.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== alu.f ====
verilog/alu_ops_pkg.sv
verilog/alu_data_pkg.sv
verilog/alu_control.sv
verilog/alu_bitslice.sv
verilog/alu_flags.sv
verilog/alu.sv
tests/alu_properties.sv
tests/tb_alu.sv

// ==== tests/alu_properties.sv ====
`timescale 1ns/100ps

// protocol checks on the registered alu outputs
module alu_properties
	import alu_ops_pkg::*;
	import alu_data_pkg::*;
#(
	parameter int WIDTH = 32
) (
	input logic             clk_i,
	input logic             rst_n_i,
	input alu_op_e          command_i,
	input logic [WIDTH-1:0] result_i, // the alu result_o
	input alu_flags_t       flags_i   // the alu flags_o
);

	logic out_valid = 1'b0; // the output register holds a computed value, not a reset value

	always @(posedge clk_i) begin
		out_valid <= rst_n_i;
	end

	// ----------------------------------------
	// flag and result rules
	// ----------------------------------------

	// carry and overflow belong to add and sub only
	a_no_arith_flags: assert property (@(posedge clk_i)
		rst_n_i && command_i != OP_ADD && command_i != OP_SUB
		|=> !flags_i.carry && !flags_i.overflow)
		else $error("carry or overflow set after a command other than add or sub");

	// slt leaves only bit 0 to carry the answer
	a_slt_upper_zero: assert property (@(posedge clk_i)
		rst_n_i && command_i == OP_SLT |=> result_i[WIDTH-1:1] == '0)
		else $error("slt result has bits set above bit 0");

	a_zero_matches: assert property (@(posedge clk_i)
		out_valid |-> flags_i.zero == (result_i == '0)) // reset values are excluded
		else $error("zero flag disagrees with the result word");

endmodule

bind alu alu_properties #(
	.WIDTH (WIDTH)
) props_i (
	.clk_i     (clk_i),
	.rst_n_i   (rst_n_i),
	.command_i (command_i),
	.result_i  (result_o),
	.flags_i   (flags_o)
);

// ==== tests/tb_alu.sv ====
`timescale 1ns/100ps

// directed testbench for the alu, every operation is checked against a behavioral model
module tb_alu
	import alu_ops_pkg::*;
	import alu_data_pkg::*;
();

	localparam int W          = ALU_WIDTH_DEFAULT;
	localparam int CLK_PERIOD = 10; // ns

	// ----------------------------------------
	// test lengths, also used by the watchdog
	// ----------------------------------------

	localparam int RESET_CYCLES   = 10;
	localparam int ADD_SUB_EDGE   = 6;
	localparam int ADD_SUB_RANDOM = 40;
	localparam int SLT_EDGE       = 6;
	localparam int SLT_RANDOM     = 30;
	localparam int LOGIC_EDGE     = 3;  // per logic command
	localparam int LOGIC_RANDOM   = 6;  // per logic command
	localparam int ZERO_CASES     = 10;
	localparam int STREAM_OPS     = 60;
	localparam int TEST_CYCLES    = RESET_CYCLES + ADD_SUB_EDGE + ADD_SUB_RANDOM + SLT_EDGE
		+ SLT_RANDOM + 5 * (LOGIC_EDGE + LOGIC_RANDOM) + ZERO_CASES + STREAM_OPS;

	localparam logic [W-1:0] ALL_ONES = '1;
	localparam logic [W-1:0] ONE      = W'(1);
	localparam logic [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}}; // most negative signed value
	localparam logic [W-1:0] MOST_POS = ~MOST_NEG;

	// expected output word of one operation
	typedef struct packed {
		logic [W-1:0] result;
		alu_flags_t   flags;
	} expect_t;

	logic             clk_i = 1'b0;
	logic             rst_n_i;
	logic [W-1:0]     operand_a_i;
	logic [W-1:0]     operand_b_i;
	alu_op_e          command_i;
	logic [W-1:0]     result_o;
	alu_flags_t       flags_o;

	logic [31:0] rng_state = 32'd40; // xorshift state
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          test_checks0;          // counts when the current test began
	int          test_errors0;
	string       test_name;

	alu #(
		.WIDTH (W)
	) dut_i (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.operand_a_i (operand_a_i),
		.operand_b_i (operand_b_i),
		.command_i   (command_i),
		.result_o    (result_o),
		.flags_o     (flags_o)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	// ----------------------------------------
	// random numbers and reference model
	// ----------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [W-1:0] rand_word();
		rng_state = xorshift32(rng_state);
		return W'(rng_state);
	endfunction

	// plain integer arithmetic, signed overflow from the operand and result signs
	function automatic expect_t model_op(input alu_op_e cmd, input logic [W-1:0] a,
		input logic [W-1:0] b);
		expect_t    e;
		logic [W:0] wide; // one extra bit catches the carry
		e.result = '0;
		e.flags = ALU_FLAGS_CLEAR;
		wide = '0;
		case (cmd)
			OP_ADD: begin
				wide = {1'b0, a} + {1'b0, b};
				e.result = wide[W-1:0];
				e.flags.carry = wide[W];
				e.flags.overflow = (a[W-1] == b[W-1]) && (e.result[W-1] != a[W-1]);
			end
			OP_SUB: begin
				e.result = a - b;
				e.flags.carry = (a >= b); // carry out means no borrow
				e.flags.overflow = (a[W-1] != b[W-1]) && (e.result[W-1] != a[W-1]);
			end
			OP_SLT:  e.result = {{(W-1){1'b0}}, ($signed(a) < $signed(b))};
			OP_XOR:  e.result = a ^ b;
			OP_AND:  e.result = a & b;
			OP_NAND: e.result = ~(a & b);
			OP_NOR:  e.result = ~(a | b);
			OP_OR:   e.result = a | b;
			default: e.result = '0;
		endcase
		e.flags.zero = (e.result == '0);
		return e;
	endfunction

	// ----------------------------------------
	// checking and bookkeeping
	// ----------------------------------------

	task automatic check_word(input string name, input logic [W-1:0] got,
		input logic [W-1:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH %s: got 0x%h expected 0x%h (test %s)", name, got, exp, test_name);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH %s: got 0x%h expected 0x%h (test %s)", name, got, exp, test_name);
			errors++;
		end
	endtask

	task automatic check_outputs(input expect_t exp);
		check_word("result_o", result_o, exp.result);
		check_bit("flags_o.carry", flags_o.carry, exp.flags.carry);
		check_bit("flags_o.overflow", flags_o.overflow, exp.flags.overflow);
		check_bit("flags_o.zero", flags_o.zero, exp.flags.zero);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_checks0 = checks;
		test_errors0 = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %s: %0d checks, %0d errors", test_name, checks - test_checks0,
			errors - test_errors0);
	endtask

	// drives one operation right after an edge and checks it one edge later
	task automatic apply_op(input alu_op_e cmd, input logic [W-1:0] a, input logic [W-1:0] b);
		expect_t exp;
		exp = model_op(cmd, a, b);
		command_i = cmd;
		operand_a_i = a;
		operand_b_i = b;
		@(posedge clk_i);
		#1;
		check_outputs(exp);
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------

	task automatic test_reset();
		expect_t cleared;
		start_test("reset");
		cleared = '{result: '0, flags: ALU_FLAGS_CLEAR};
		command_i = OP_ADD;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			// even cycles would give zero with carry and overflow, odd ones a nonzero sum
			operand_a_i = (i % 2 == 0) ? MOST_NEG : ALL_ONES;
			operand_b_i = operand_a_i;
			@(posedge clk_i);
			#1;
			check_outputs(cleared);
		end
		rst_n_i = 1'b1;
		end_test();
	endtask

	task automatic test_add_sub();
		logic [W-1:0] a;
		logic [W-1:0] b;
		start_test("add_sub");
		a = rand_word();
		apply_op(OP_ADD, ALL_ONES, ONE);                     // wraps to zero with carry
		apply_op(OP_ADD, MOST_NEG, MOST_NEG);                // negative overflow
		apply_op(OP_ADD, MOST_POS - W'(5), MOST_POS - W'(9)); // positive overflow
		apply_op(OP_SUB, a, a);
		apply_op(OP_SUB, '0, ONE);                           // borrow, so no carry
		apply_op(OP_SUB, MOST_NEG, ONE);
		for (int i = 0; i < ADD_SUB_RANDOM; i++) begin
			a = rand_word();
			b = rand_word();
			apply_op((i % 2 == 0) ? OP_ADD : OP_SUB, a, b);
		end
		end_test();
	endtask

	task automatic test_slt();
		logic [W-1:0] a;
		logic [W-1:0] b;
		start_test("slt");
		a = rand_word();
		apply_op(OP_SLT, ALL_ONES, ONE);      // minus one below one
		apply_op(OP_SLT, ONE, ALL_ONES);
		apply_op(OP_SLT, MOST_NEG, ONE);      // the subtraction overflows here
		apply_op(OP_SLT, MOST_POS, ALL_ONES); // and here, the other way round
		apply_op(OP_SLT, MOST_NEG, MOST_POS);
		apply_op(OP_SLT, a, a);
		for (int i = 0; i < SLT_RANDOM; i++) begin
			a = rand_word();
			b = rand_word();
			apply_op(OP_SLT, a, b);
		end
		end_test();
	endtask

	task automatic test_logic();
		alu_op_e      ops [5] = '{OP_XOR, OP_AND, OP_NAND, OP_NOR, OP_OR};
		logic [W-1:0] a;
		logic [W-1:0] b;
		start_test("logic");
		foreach (ops[k]) begin
			apply_op(ops[k], ALL_ONES, ALL_ONES);
			apply_op(ops[k], '0, ALL_ONES);
			apply_op(ops[k], '0, '0);
			for (int i = 0; i < LOGIC_RANDOM; i++) begin
				a = rand_word();
				b = rand_word();
				apply_op(ops[k], a, b);
			end
		end
		end_test();
	endtask

	task automatic test_zero_flag();
		logic [W-1:0] a;
		start_test("zero_flag");
		a = rand_word() | ONE; // never zero
		apply_op(OP_XOR, a, a);
		apply_op(OP_AND, a, '0);
		apply_op(OP_SUB, a, a);
		apply_op(OP_SLT, W'(5), W'(3)); // false gives an all zero word
		apply_op(OP_NOR, ALL_ONES, a);
		apply_op(OP_OR, '0, '0);
		apply_op(OP_ADD, ALL_ONES, ONE);
		apply_op(OP_ADD, ONE, W'(2));   // the rest must leave zero clear
		apply_op(OP_XOR, ONE, W'(2));
		apply_op(OP_SLT, W'(3), W'(5));
		end_test();
	endtask

	task automatic test_streaming();
		logic [W-1:0] a;
		logic [W-1:0] b;
		alu_op_e      cmd;
		start_test("streaming");
		for (int i = 0; i < STREAM_OPS; i++) begin
			cmd = alu_op_e'(3'(rand_word()));
			a = rand_word();
			b = rand_word();
			apply_op(cmd, a, b); // next call drives right after this check, no idle cycle
		end
		end_test();
	endtask

	// ----------------------------------------
	// sequence and summary
	// ----------------------------------------

	initial begin
		rst_n_i = 1'b0;
		command_i = OP_ADD;
		operand_a_i = '0;
		operand_b_i = '0;
		test_reset();
		test_add_sub();
		test_slt();
		test_logic();
		test_zero_flag();
		test_streaming();
		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// ends a stuck run, one cycle per operation plus some slack
	initial begin
		#((TEST_CYCLES + 20) * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", TEST_CYCLES + 20);
		$display("Verification failed");
		$finish;
	end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/100ps

// ripple carry alu with eight commands and a single output register stage
// inputs sampled on one rising edge show up on result_o and flags_o right after it
module alu
	import alu_ops_pkg::*;
	import alu_data_pkg::*;
#(
	parameter int WIDTH = ALU_WIDTH_DEFAULT // any width of 2 or more
) (
	input  logic             clk_i,
	input  logic             rst_n_i,     // synchronous, active low
	input  logic [WIDTH-1:0] operand_a_i,
	input  logic [WIDTH-1:0] operand_b_i,
	input  alu_op_e          command_i,   // a new operation every cycle, no handshake
	output logic [WIDTH-1:0] result_o,    // registered result
	output alu_flags_t       flags_o      // registered flags, same cycle as result_o
);

	alu_ctrl_t        ctrl;          // decoded once and fanned out to every slice
	logic [WIDTH:0]   carry;         // carry[i] enters slice i, carry[WIDTH] leaves the msb
	logic [WIDTH-1:0] raw_result;    // slice outputs before slt forcing
	logic [WIDTH-1:0] result_d;      // final result ahead of the register
	alu_flags_t       flags_d;       // flags ahead of the register

	// ----------------------------------------
	// command decode
	// ----------------------------------------

	alu_control control_i (
		.command_i (command_i),
		.ctrl_o    (ctrl)
	);

	// ----------------------------------------
	// slice chain
	// ----------------------------------------

	// the sub bit doubles as the plus one of the two's complement
	assign carry[0] = ctrl.sub;

	for (genvar i = 0; i < WIDTH; i++) begin : g_slice
		alu_bitslice slice_i (
			.a_i      (operand_a_i[i]),
			.b_i      (operand_b_i[i]),
			.carry_i  (carry[i]),
			.ctrl_i   (ctrl),
			.result_o (raw_result[i]),
			.carry_o  (carry[i+1])       // ripples into the next slice up
		);
	end

	// ----------------------------------------
	// result conditioning and flags
	// ----------------------------------------

	alu_flags #(
		.WIDTH (WIDTH)
	) flags_i (
		.raw_result_i (raw_result),
		.msb_carry_i  (carry[WIDTH-1]), // carry into the msb slice, needed for overflow
		.carry_out_i  (carry[WIDTH]),
		.ctrl_i       (ctrl),
		.result_o     (result_d),
		.flags_o      (flags_d)
	);

	// ----------------------------------------
	// output register
	// ----------------------------------------

	// reset clears everything, the zero flag too, even though the result reads zero
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			result_o <= '0;
			flags_o  <= '0;
		end else begin
			result_o <= result_d; // one cycle of latency, no stalls
			flags_o  <= flags_d;
		end
	end

endmodule

// ==== verilog/alu_bitslice.sv ====
`timescale 1ns/100ps

// one bit of the data path
// holds a full adder for add, sub and slt plus the five bitwise gates, then a select
module alu_bitslice import alu_ops_pkg::*; (
	input  logic      a_i,      // this bit of operand a
	input  logic      b_i,      // this bit of operand b
	input  logic      carry_i,  // carry from the slice below, or the sub bit for slice 0
	input  alu_ctrl_t ctrl_i,   // decoded command, identical in every slice
	output logic      result_o, // raw result bit before slt forcing
	output logic      carry_o   // carry into the slice above
);

	logic b_add;     // b as the adder sees it
	logic half_sum;  // a xor b_add, shared by the sum and the carry
	logic sum;
	logic gate_xor;
	logic gate_and;
	logic gate_or;

	// ----------------------------------------
	// adder
	// ----------------------------------------

	// two's complement subtraction is a plus not b plus one, the plus one arrives on carry 0
	assign b_add    = b_i ^ ctrl_i.sub;
	assign half_sum = a_i ^ b_add;
	assign sum      = half_sum ^ carry_i;
	assign carry_o  = (a_i & b_add) | (carry_i & half_sum); // generate or propagate

	// ----------------------------------------
	// logic unit
	// ----------------------------------------

	// these use the original b, the sub inversion never reaches them
	assign gate_xor = a_i ^ b_i;
	assign gate_and = a_i & b_i;
	assign gate_or  = a_i | b_i;

	// ----------------------------------------
	// result select
	// ----------------------------------------

	always_comb begin
		case (ctrl_i.sel)
			SEL_SUM:  result_o = sum;
			SEL_XOR:  result_o = gate_xor;
			SEL_AND:  result_o = gate_and;
			SEL_NAND: result_o = ~gate_and; // nand and nor reuse the and and or terms
			SEL_NOR:  result_o = ~gate_or;
			SEL_OR:   result_o = gate_or;
			default:  result_o = 1'b0;      // unused select codes give a quiet zero
		endcase
	end

endmodule

// ==== verilog/alu_control.sv ====
`timescale 1ns/100ps

// turns the three bit command into the control word that steers the whole data path
// decoding happens once here instead of inside every slice
module alu_control import alu_ops_pkg::*; (
	input  alu_op_e   command_i, // command straight from the alu port
	output alu_ctrl_t ctrl_o     // shared by all slices and the flag unit
);

	always_comb begin
		// safe value for an unknown command, behaves like a plain add with no flags
		ctrl_o = '{sel: SEL_SUM, sub: 1'b0, slt_mode: 1'b0, arith_mode: 1'b0};

		case (command_i)
			// ----------------------------------------
			// adder based operations
			// ----------------------------------------
			OP_ADD: begin
				ctrl_o = '{sel: SEL_SUM, sub: 1'b0, slt_mode: 1'b0, arith_mode: 1'b1};
			end
			OP_SUB: begin
				ctrl_o = '{sel: SEL_SUM, sub: 1'b1, slt_mode: 1'b0, arith_mode: 1'b1};
			end
			OP_SLT: begin // a minus b is computed, only its sign survives
				ctrl_o = '{sel: SEL_SUM, sub: 1'b1, slt_mode: 1'b1, arith_mode: 1'b0};
			end

			// ----------------------------------------
			// bitwise operations
			// ----------------------------------------
			OP_XOR: begin
				ctrl_o = '{sel: SEL_XOR, sub: 1'b0, slt_mode: 1'b0, arith_mode: 1'b0};
			end
			OP_AND: begin
				ctrl_o = '{sel: SEL_AND, sub: 1'b0, slt_mode: 1'b0, arith_mode: 1'b0};
			end
			OP_NAND: begin
				ctrl_o = '{sel: SEL_NAND, sub: 1'b0, slt_mode: 1'b0, arith_mode: 1'b0};
			end
			OP_NOR: begin
				ctrl_o = '{sel: SEL_NOR, sub: 1'b0, slt_mode: 1'b0, arith_mode: 1'b0};
			end
			OP_OR: begin
				ctrl_o = '{sel: SEL_OR, sub: 1'b0, slt_mode: 1'b0, arith_mode: 1'b0};
			end
		endcase
	end

endmodule

// ==== verilog/alu_data_pkg.sv ====
package alu_data_pkg;

	// ----------------------------------------
	// data path sizing
	// ----------------------------------------

	// width used when the top level is not given one, any value of 2 or more works
	parameter int ALU_WIDTH_DEFAULT = 32;

	// ----------------------------------------
	// status flags
	// ----------------------------------------

	// registered alongside the result so both appear in the same cycle
	typedef struct packed {
		logic carry;    // carry out of the msb, add and sub only
		logic overflow; // signed overflow, add and sub only
		logic zero;     // every result bit is zero
	} alu_flags_t;

	// the testbench compares whole flag words, so a named empty value keeps that readable
	parameter alu_flags_t ALU_FLAGS_CLEAR = '{carry: 1'b0, overflow: 1'b0, zero: 1'b0};

endpackage

// ==== verilog/alu_flags.sv ====
`timescale 1ns/100ps

// conditions the raw slice outputs into the final result and the three flags
// everything here is combinational, the top level registers it
module alu_flags
	import alu_ops_pkg::*;
	import alu_data_pkg::*;
#(
	parameter int WIDTH = 32 // data width, the top level always sets it
) (
	input  logic [WIDTH-1:0] raw_result_i, // one bit from each slice
	input  logic             msb_carry_i,  // carry into the msb slice
	input  logic             carry_out_i,  // carry out of the msb slice
	input  alu_ctrl_t        ctrl_i,
	output logic [WIDTH-1:0] result_o,     // final combinational result
	output alu_flags_t       flags_o
);

	logic overflow_raw;     // signed overflow of whatever the adder did, any command
	logic neg_overflow;     // overflowed while going below the most negative value
	logic less_than;        // a below b as signed numbers, valid when the adder subtracted
	logic [WIDTH-1:0] slt_word;

	// ----------------------------------------
	// signed compare
	// ----------------------------------------

	// carry in and carry out of the msb disagree exactly when the signed result wrapped
	assign overflow_raw = msb_carry_i ^ carry_out_i;

	// carry out without carry in means two negatives gave a positive msb, so a is below b
	assign neg_overflow = carry_out_i & ~msb_carry_i;

	// with no wrap the sign bit of a minus b tells the answer directly
	assign less_than = overflow_raw ? neg_overflow : raw_result_i[WIDTH-1];

	// slt returns a full word that is either one or zero
	assign slt_word = {{(WIDTH-1){1'b0}}, less_than};

	// ----------------------------------------
	// result and flags
	// ----------------------------------------

	assign result_o = ctrl_i.slt_mode ? slt_word : raw_result_i;

	always_comb begin
		// carry and overflow mean nothing outside add and sub, slt included
		flags_o.carry    = carry_out_i & ctrl_i.arith_mode;
		flags_o.overflow = overflow_raw & ctrl_i.arith_mode;
		flags_o.zero     = ~|result_o; // taken after slt forcing so it matches the output word
	end

endmodule

// ==== verilog/alu_ops_pkg.sv ====
package alu_ops_pkg;

	// ----------------------------------------
	// command encoding seen on the alu port
	// ----------------------------------------

	// the values keep the original three bit command table so existing programs still work
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0, // a plus b
		OP_SUB  = 3'd1, // a minus b through the same adder chain
		OP_XOR  = 3'd2,
		OP_SLT  = 3'd3, // one when a is less than b as signed numbers
		OP_AND  = 3'd4,
		OP_NAND = 3'd5,
		OP_NOR  = 3'd6,
		OP_OR   = 3'd7
	} alu_op_e;

	// ----------------------------------------
	// per slice result select
	// ----------------------------------------

	// add, sub and slt all take the adder output, so six choices are enough
	typedef enum logic [2:0] {
		SEL_SUM  = 3'd0, // full adder sum bit
		SEL_XOR  = 3'd1,
		SEL_AND  = 3'd2,
		SEL_NAND = 3'd3,
		SEL_NOR  = 3'd4,
		SEL_OR   = 3'd5 // codes 6 and 7 are never produced by the decoder
	} alu_sel_e;

	// ----------------------------------------
	// decoded control word
	// ----------------------------------------

	// one copy of this goes to every slice and to the flag unit
	typedef struct packed {
		alu_sel_e sel;        // which slice result reaches the raw result bit
		logic     sub;        // inverts b in every slice and feeds the first carry in
		logic     slt_mode;   // the flag unit replaces the result with the less-than bit
		logic     arith_mode; // carry and overflow are only meaningful for add and sub
	} alu_ctrl_t;

endpackage
